/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int LSQ_DEPTH = 4;
    localparam int LSQ_IDX_W = $clog2(LSQ_DEPTH);
    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = 6;
    localparam int ROB_IDX_W = 5;

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3[1:0] is the size, funct3[2] means zero extension
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } stype_t;

    // loads decode the word as I-type, stores as S-type
    typedef union packed {
        itype_t i;
        stype_t s;
    } inst_word_u;

    typedef struct packed {
        inst_word_u           inst;
        logic [PREG_W-1:0]    prs1;
        logic [PREG_W-1:0]    prs2;
        logic [PREG_W-1:0]    prd;
        logic [ROB_IDX_W-1:0] rob_idx;
    } renamed_inst_t;

    typedef struct packed {
        logic                 is_store;
        logic [2:0]           funct3;
        logic [PREG_W-1:0]    prs1;
        logic [PREG_W-1:0]    prs2;
        logic [PREG_W-1:0]    prd;
        logic [31:0]          imm;
        logic [ROB_IDX_W-1:0] rob_idx;
    } lsq_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [PREG_W-1:0]    prd;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [31:0]          data;
    } ls_result_t;

endpackage

`default_nettype wire

/* design/ls_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_dispatch
    import lsu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 flush,
    input  wire logic                 disp_valid,
    input  wire renamed_inst_t        disp_inst,
    output logic      [LSQ_DEPTH-1:0] slot_wr,
    output lsq_entry_t                wr_entry
);

    logic [LSQ_IDX_W-1:0] tail;
    logic                 is_load;
    logic                 is_store;
    logic                 wr_en;

    assign is_load  = disp_inst.inst.i.opcode == OP_LOAD;
    assign is_store = disp_inst.inst.s.opcode == OP_STORE;
    assign wr_en    = disp_valid && !flush;

    always_comb
    begin
        wr_entry.is_store = is_store;
        // funct3 sits in the same bits in both formats
        wr_entry.funct3   = disp_inst.inst.i.funct3;
        wr_entry.prs1     = disp_inst.prs1;
        wr_entry.rob_idx  = disp_inst.rob_idx;
        if (is_store)
        begin
            wr_entry.imm    = {{20{disp_inst.inst.s.imm_hi[6]}},
                               disp_inst.inst.s.imm_hi, disp_inst.inst.s.imm_lo};
            wr_entry.prs2   = disp_inst.prs2;
            wr_entry.prd    = '0;
        end
        else
        begin
            wr_entry.imm    = {{20{disp_inst.inst.i.imm[11]}}, disp_inst.inst.i.imm};
            // loads carry no rs2
            wr_entry.prs2   = '0;
            wr_entry.prd    = disp_inst.prd;
        end
    end

    assign slot_wr = wr_en ? (LSQ_DEPTH'(1) << tail) : '0;

    // tail wraps at the power-of-two depth
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            tail <= '0;
        else if (flush)
            tail <= '0;
        else if (wr_en)
            tail <= tail + 1'b1;
    end

    a_ldst_only: assert property (@(posedge clk) disable iff (!arst_n)
        disp_valid |-> (is_load || is_store));

endmodule

`default_nettype wire

/* design/ls_queue_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_queue_slot
    import lsu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 flush,
    input  wire logic                 wr,
    input  wire logic                 clr,
    input  wire lsq_entry_t           wr_entry,
    input  wire logic [NUM_PREGS-1:0] preg_valid,
    output lsq_entry_t                entry,
    output logic                      slot_valid,
    output logic                      slot_ready
);

    logic rs1_ok;
    logic rs2_ok;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            slot_valid <= 1'b0;
        else if (flush || clr)
            slot_valid <= 1'b0;
        else if (wr)
            slot_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wr)
            entry <= wr_entry;
    end

    // p0 is hardwired zero, never waits
    assign rs1_ok     = (entry.prs1 == '0) || preg_valid[entry.prs1];
    assign rs2_ok     = !entry.is_store || (entry.prs2 == '0) || preg_valid[entry.prs2];
    assign slot_ready = rs1_ok && rs2_ok;

    // tail and head only meet on an empty or full queue
    a_wr_clr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(wr && clr));

endmodule

`default_nettype wire

/* design/ls_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_issue_select
    import lsu_pkg::*;
(
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic                              flush,
    input  wire logic                              disp_valid,
    input  wire logic                              mem_free,
    input  wire lsq_entry_t [LSQ_DEPTH-1:0]        slot_entries,
    input  wire logic       [LSQ_DEPTH-1:0]        slot_valid,
    input  wire logic       [LSQ_DEPTH-1:0]        slot_ready,
    output lsq_entry_t                             head_entry,
    output logic            [PREG_W-1:0]           rs1_idx,
    output logic            [PREG_W-1:0]           rs2_idx,
    output logic                                   issue,
    output logic            [LSQ_DEPTH-1:0]        slot_clr,
    output logic                                   lsq_full
);

    logic [LSQ_IDX_W-1:0] head;
    logic [LSQ_IDX_W:0]   count;

    assign head_entry = slot_entries[head];
    assign rs1_idx    = head_entry.prs1;
    assign rs2_idx    = head_entry.prs2;

    // strictly in order, a stalled head blocks everything behind it
    assign issue    = slot_valid[head] && slot_ready[head] && mem_free && !flush;
    assign slot_clr = issue ? (LSQ_DEPTH'(1) << head) : '0;
    assign lsq_full = count == (LSQ_IDX_W + 1)'(LSQ_DEPTH);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            head  <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            head  <= '0;
            count <= '0;
        end
        else
        begin
            if (issue)
                head <= head + 1'b1;
            if (disp_valid && !issue)
                count <= count + 1'b1;
            else if (!disp_valid && issue)
                count <= count - 1'b1;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= LSQ_DEPTH);

endmodule

`default_nettype wire

/* design/ls_address_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_address_unit
    import lsu_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        flush,
    input  wire logic        issue,
    input  wire lsq_entry_t  head_entry,
    input  wire logic [31:0] rs1_val,
    input  wire logic [31:0] rs2_val,
    input  wire logic [31:0] dmem_rdata,
    input  wire logic        dmem_resp,
    output dmem_req_t        dmem_req,
    output logic             mem_free,
    output ls_result_t       result
);

    logic [31:0]          eff_addr;
    logic [1:0]           off;
    logic [3:0]           lane_mask;
    logic [31:0]          lane_data;
    logic                 outstanding;
    logic                 live;
    logic                 q_store;
    logic [2:0]           q_funct3;
    logic [1:0]           q_off;
    logic [PREG_W-1:0]    q_prd;
    logic [ROB_IDX_W-1:0] q_rob;
    logic [31:0]          shifted;
    logic [31:0]          load_data;

    assign eff_addr = rs1_val + head_entry.imm;
    assign off      = eff_addr[1:0];

    always_comb
    begin
        case (head_entry.funct3[1:0])
            2'b00:
            begin
                lane_mask = 4'b0001 << off;
                lane_data = {24'b0, rs2_val[7:0]} << {off, 3'b000};
            end
            2'b01:
            begin
                lane_mask = 4'b0011 << off;
                lane_data = {16'b0, rs2_val[15:0]} << {off, 3'b000};
            end
            2'b10:
            begin
                lane_mask = 4'b1111;
                lane_data = rs2_val;
            end
            default:
            begin
                lane_mask = 4'b0000;
                lane_data = '0;
            end
        endcase
    end

    // request only exists in the issue cycle
    always_comb
    begin
        dmem_req = '0;
        if (issue)
        begin
            dmem_req.addr = {eff_addr[31:2], 2'b00};
            if (head_entry.is_store)
            begin
                dmem_req.wmask = lane_mask;
                dmem_req.wdata = lane_data;
            end
            else
            begin
                dmem_req.rmask = lane_mask;
            end
        end
    end

    // outstanding tracks the memory, live tracks whether the result is still wanted.
    // a flushed access keeps the port busy until its response drains.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            outstanding <= 1'b0;
            live        <= 1'b0;
        end
        else
        begin
            if (issue)
                outstanding <= 1'b1;
            else if (dmem_resp)
                outstanding <= 1'b0;
            if (flush || dmem_resp)
                live <= 1'b0;
            else if (issue)
                live <= 1'b1;
        end
    end

    assign mem_free = !outstanding;

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            q_store  <= head_entry.is_store;
            q_funct3 <= head_entry.funct3;
            q_off    <= off;
            q_prd    <= head_entry.prd;
            q_rob    <= head_entry.rob_idx;
        end
    end

    assign shifted = dmem_rdata >> {q_off, 3'b000};

    always_comb
    begin
        case (q_funct3)
            F3_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            F3_LBU:  load_data = {24'b0, shifted[7:0]};
            F3_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            F3_LHU:  load_data = {16'b0, shifted[15:0]};
            default: load_data = dmem_rdata;
        endcase
    end

    always_comb
    begin
        result.valid   = dmem_resp && live && !flush;
        result.we      = result.valid && !q_store;
        result.prd     = q_prd;
        result.rob_idx = q_rob;
        result.data    = q_store ? '0 : load_data;
    end

    a_resp_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_resp |-> !mem_free);

endmodule

`default_nettype wire

/* design/lsu_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys_top
    import lsu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 flush,
    input  wire logic                 disp_valid,
    input  wire renamed_inst_t        disp_inst,
    input  wire logic [NUM_PREGS-1:0] preg_valid,
    output logic      [PREG_W-1:0]    rs1_idx,
    output logic      [PREG_W-1:0]    rs2_idx,
    input  wire logic [31:0]          rs1_val,
    input  wire logic [31:0]          rs2_val,
    output dmem_req_t                 dmem_req,
    input  wire logic [31:0]          dmem_rdata,
    input  wire logic                 dmem_resp,
    output logic                      lsq_full,
    output ls_result_t                result
);

    logic       [LSQ_DEPTH-1:0] slot_wr;
    lsq_entry_t                 wr_entry;
    lsq_entry_t [LSQ_DEPTH-1:0] slot_entries;
    logic       [LSQ_DEPTH-1:0] slot_valid;
    logic       [LSQ_DEPTH-1:0] slot_ready;
    logic       [LSQ_DEPTH-1:0] slot_clr;
    lsq_entry_t                 head_entry;
    logic                       issue;
    logic                       mem_free;

    ls_dispatch ls_dispatch_i (.*);

    for (genvar g = 0; g < LSQ_DEPTH; g++)
    begin : g_slot
        ls_queue_slot ls_queue_slot_i (
            .clk        (clk),
            .arst_n     (arst_n),
            .flush      (flush),
            .wr         (slot_wr[g]),
            .clr        (slot_clr[g]),
            .wr_entry   (wr_entry),
            .preg_valid (preg_valid),
            .entry      (slot_entries[g]),
            .slot_valid (slot_valid[g]),
            .slot_ready (slot_ready[g])
        );
    end

    ls_issue_select ls_issue_select_i (.*);

    ls_address_unit ls_address_unit_i (.*);

endmodule

`default_nettype wire

/* verif/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    typedef struct packed {
        dmem_req_t  req;
        ls_result_t res;
    } expect_t;

    logic                 clk;
    logic                 arst_n;
    logic                 flush;
    logic                 disp_valid;
    renamed_inst_t        disp_inst;
    logic [NUM_PREGS-1:0] preg_valid;
    logic [PREG_W-1:0]    rs1_idx;
    logic [PREG_W-1:0]    rs2_idx;
    logic [31:0]          rs1_val;
    logic [31:0]          rs2_val;
    dmem_req_t            dmem_req;
    logic [31:0]          dmem_rdata;
    logic                 dmem_resp;
    logic                 lsq_full;
    ls_result_t           result;

    logic [31:0]          rf [NUM_PREGS];
    logic [31:0]          mem [256];
    renamed_inst_t        req_q [$];
    ls_result_t           exp_q [$];
    string                test_name;
    integer               seed = 65145;
    int                   n_err;
    int                   n_checks;
    int                   n_disp;
    logic                 hold_resp;
    logic [PREG_W-1:0]    next_preg;
    logic [ROB_IDX_W-1:0] next_rob;
    logic [PREG_W-1:0]    last_prs1;
    logic [PREG_W-1:0]    last_prs2;

    lsu_subsys_top lsu_subsys_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_inst  (disp_inst),
        .preg_valid (preg_valid),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .lsq_full   (lsq_full),
        .result     (result)
    );

    // register file model answers in the same cycle
    assign rs1_val = rf[rs1_idx];
    assign rs2_val = rf[rs2_idx];

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected request and completion from the raw instruction bits
    function automatic expect_t compute_expected(input renamed_inst_t ri,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [31:0] w;
        logic        st;
        logic [31:0] ea;
        logic [31:0] word;
        logic [31:0] raw;
        int          size;
        int          off;
        int          i;
        expect_t     e;
        w    = ri.inst;
        st   = w[6:0] == OP_STORE;
        ea   = a + (st ? {{20{w[31]}}, w[31:25], w[11:7]} : {{20{w[31]}}, w[31:20]});
        off  = ea[1:0];
        size = 1 << w[13:12];
        word = mem[ea[9:2]];
        raw  = '0;
        e    = '0;
        e.req.addr = {ea[31:2], 2'b00};
        for (i = 0; i < size; i++)
        begin
            if (st)
            begin
                e.req.wmask[off + i]          = 1'b1;
                e.req.wdata[8*(off + i) +: 8] = b[8*i +: 8];
            end
            else
            begin
                e.req.rmask[off + i] = 1'b1;
                raw[8*i +: 8]        = word[8*(off + i) +: 8];
            end
        end
        e.res.valid   = 1'b1;
        e.res.we      = !st;
        e.res.prd     = st ? '0 : ri.prd;
        e.res.rob_idx = ri.rob_idx;
        case (w[14:12])
            F3_LB:   e.res.data = {{24{raw[7]}}, raw[7:0]};
            F3_LH:   e.res.data = {{16{raw[15]}}, raw[15:0]};
            default: e.res.data = raw;
        endcase
        if (st)
            e.res.data = '0;
        return e;
    endfunction

    task automatic check_equal(input string what, input logic [95:0] exp,
                               input logic [95:0] act);
        n_checks++;
        assert (act === exp)
        else
        begin
            n_err++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic take_preg(output logic [PREG_W-1:0] p);
        p         = next_preg;
        next_preg = (next_preg == PREG_W'(NUM_PREGS - 1)) ? PREG_W'(1) : next_preg + 1'b1;
    endtask

    task automatic dispatch_op(input logic st, input logic [2:0] f3, input logic [11:0] imm,
                               input logic [31:0] base, input logic [31:0] data,
                               input logic rs1_rdy, input logic rs2_rdy);
        renamed_inst_t     ri;
        logic [PREG_W-1:0] pd;
        take_preg(last_prs1);
        take_preg(last_prs2);
        take_preg(pd);
        if (st)
            ri.inst = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OP_STORE};
        else
            ri.inst = {imm, 5'd1, f3, 5'd3, OP_LOAD};
        ri.prs1               = last_prs1;
        ri.prs2               = last_prs2;
        ri.prd                = pd;
        ri.rob_idx            = next_rob;
        next_rob              = next_rob + 1'b1;
        rf[last_prs1]         = base;
        rf[last_prs2]         = data;
        preg_valid[last_prs1] = rs1_rdy;
        preg_valid[last_prs2] = rs2_rdy;
        while (lsq_full)
        begin
            @(posedge clk);
            #1;
        end
        disp_inst  = ri;
        disp_valid = 1'b1;
        req_q.push_back(ri);
        n_disp++;
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic drain_all();
        while (req_q.size() != 0 || exp_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic wait_issued();
        while (req_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // memory samples the request mid-cycle and answers 1 to 4 cycles later
    initial
    begin : memory_model
        expect_t e;
        int      widx;
        int      b;
        int      delay;
        dmem_resp  = 1'b0;
        dmem_rdata = '0;
        for (widx = 0; widx < 256; widx++)
            mem[widx] = 32'h9e37_79b9 * (widx + 1);
        forever
        begin
            @(negedge clk);
            if (dmem_req.rmask != '0 || dmem_req.wmask != '0)
            begin
                widx = dmem_req.addr[9:2];
                assert (req_q.size() > 0)
                else
                begin
                    n_err++;
                    $display("%s: memory request with no instruction waiting", test_name);
                end
                if (req_q.size() > 0)
                begin
                    e = compute_expected(req_q[0], rf[req_q[0].prs1], rf[req_q[0].prs2]);
                    check_equal("rs1_idx", req_q[0].prs1, rs1_idx);
                    // loads read no rs2
                    if (req_q[0].inst.s.opcode == OP_STORE)
                        check_equal("rs2_idx", req_q[0].prs2, rs2_idx);
                    else
                        check_equal("rs2_idx", '0, rs2_idx);
                    void'(req_q.pop_front());
                    check_equal("request", e.req, dmem_req);
                    exp_q.push_back(e.res);
                end
                for (b = 0; b < 4; b++)
                    if (dmem_req.wmask[b])
                        mem[widx][8*b +: 8] = dmem_req.wdata[8*b +: 8];
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                while (hold_resp)
                    @(posedge clk);
                #1;
                dmem_rdata = mem[widx];
                dmem_resp  = 1'b1;
                @(posedge clk);
                #1;
                dmem_resp  = 1'b0;
            end
        end
    end

    initial
    begin : comparator
        ls_result_t e;
        forever
        begin
            @(negedge clk);
            if (result.valid)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    n_err++;
                    $display("%s: result appeared with no completion expected", test_name);
                end
                if (exp_q.size() > 0)
                begin
                    e = exp_q.pop_front();
                    check_equal("result", e, result);
                end
            end
        end
    end

    // budget grows with every dispatched instruction
    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < (n_disp + 2) * 40)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout in %s: no progress after %0d cycles, %0d errors so far",
                 test_name, cycles, n_err);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin : stimulus
        int                o;
        logic [PREG_W-1:0] blocked_rs1;
        logic [PREG_W-1:0] blocked_rs2;
        arst_n     = 1'b0;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp_inst  = '0;
        preg_valid = '1;
        hold_resp  = 1'b0;
        next_preg  = PREG_W'(1);
        next_rob   = '0;
        test_name  = "reset";
        for (o = 0; o < NUM_PREGS; o++)
            rf[o] = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_equal("lsq_full", 1'b0, lsq_full);
        check_equal("dmem_req", '0, dmem_req);
        check_equal("result.valid", 1'b0, result.valid);

        test_name = "load widths";
        for (o = 0; o < 4; o++)
        begin
            dispatch_op(1'b0, F3_LB, 12'(o), 32'h100, '0, 1'b1, 1'b1);
            dispatch_op(1'b0, F3_LBU, 12'(o), 32'h104, '0, 1'b1, 1'b1);
        end
        for (o = 0; o < 4; o += 2)
        begin
            dispatch_op(1'b0, F3_LH, 12'(o), 32'h108, '0, 1'b1, 1'b1);
            dispatch_op(1'b0, F3_LHU, 12'(o), 32'h10c, '0, 1'b1, 1'b1);
        end
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h110, '0, 1'b1, 1'b1);
        drain_all();

        test_name = "store merge";
        dispatch_op(1'b1, F3_SW, 12'h0, 32'h180, 32'h1122_3344, 1'b1, 1'b1);
        dispatch_op(1'b1, F3_SB, 12'h1, 32'h180, 32'hffff_ffab, 1'b1, 1'b1);
        dispatch_op(1'b1, F3_SH, 12'h2, 32'h180, 32'h5a5a_cdef, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h180, '0, 1'b1, 1'b1);
        for (o = 0; o < 4; o++)
            dispatch_op(1'b1, F3_SB, 12'(o), 32'h184, 32'(32'h80 + o), 1'b1, 1'b1);
        dispatch_op(1'b1, F3_SH, 12'h2, 32'h188, 32'h0000_8001, 1'b1, 1'b1);
        dispatch_op(1'b1, F3_SH, 12'h0, 32'h188, 32'hffff_7ffe, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h184, '0, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h188, '0, 1'b1, 1'b1);
        drain_all();
        check_equal("merged word", 32'hcdef_ab44, mem[8'h60]);

        // negative and extreme immediates
        test_name = "address calc";
        dispatch_op(1'b0, F3_LW, 12'hffc, 32'h210, '0, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LB, 12'hffa, 32'h205, '0, 1'b1, 1'b1);
        dispatch_op(1'b1, F3_SH, 12'h801, 32'h9fd, 32'h0000_7777, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LHU, 12'h7fe, 32'h0, '0, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LH, 12'h00e, 32'h1f0, '0, 1'b1, 1'b1);
        drain_all();

        test_name = "operand wait";
        dispatch_op(1'b0, F3_LW, 12'h4, 32'h140, '0, 1'b0, 1'b1);
        blocked_rs1 = last_prs1;
        dispatch_op(1'b1, F3_SW, 12'h8, 32'h140, 32'hdead_beef, 1'b1, 1'b0);
        blocked_rs2 = last_prs2;
        dispatch_op(1'b0, F3_LW, 12'h8, 32'h140, '0, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LB, 12'h9, 32'h140, '0, 1'b1, 1'b1);
        repeat (10) @(posedge clk);
        #1;
        check_equal("held entries", 4, req_q.size());
        preg_valid[blocked_rs1] = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        check_equal("held behind store", 3, req_q.size());
        preg_valid[blocked_rs2] = 1'b1;
        drain_all();

        test_name = "queue full";
        hold_resp = 1'b1;
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h1c0, '0, 1'b1, 1'b1);
        wait_issued();
        for (o = 1; o <= LSQ_DEPTH; o++)
        begin
            dispatch_op(1'b0, F3_LW, 12'(4 * o), 32'h1c0, '0, 1'b1, 1'b1);
            check_equal("lsq_full", o == LSQ_DEPTH, lsq_full);
        end
        hold_resp = 1'b0;
        while (lsq_full)
        begin
            @(posedge clk);
            #1;
        end
        drain_all();

        // store in flight plus a full queue get dropped
        test_name = "flush";
        hold_resp = 1'b1;
        dispatch_op(1'b1, F3_SW, 12'h0, 32'h1e0, 32'h0bad_f00d, 1'b1, 1'b1);
        wait_issued();
        for (o = 0; o < LSQ_DEPTH; o++)
            dispatch_op(1'b0, F3_LW, 12'(4 * o), 32'h1e0, '0, 1'b1, 1'b1);
        check_equal("lsq_full before flush", 1'b1, lsq_full);
        flush = 1'b1;
        req_q.delete();
        exp_q.delete();
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_equal("lsq_full after flush", 1'b0, lsq_full);
        hold_resp = 1'b0;
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h1e0, '0, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LBU, 12'h3, 32'h1e0, '0, 1'b1, 1'b1);
        dispatch_op(1'b1, F3_SB, 12'h1, 32'h1e0, 32'h0000_0066, 1'b1, 1'b1);
        dispatch_op(1'b0, F3_LW, 12'h0, 32'h1e0, '0, 1'b1, 1'b1);
        drain_all();

        $display("checks: %0d, errors: %0d", n_checks, n_err);
        if (n_err == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_subsys.f */
design/lsu_pkg.sv
design/ls_dispatch.sv
design/ls_queue_slot.sv
design/ls_issue_select.sv
design/ls_address_unit.sv
design/lsu_subsys_top.sv
verif/lsu_tb.sv
